/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= icacheTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+rtl
rtl/icachePkg.sv
rtl/icacheDataSram.sv
rtl/icacheTagStore.sv
rtl/icacheRefill.sv
rtl/icacheCtrl.sv
rtl/icacheTop.sv
verification/clockGen.sv
verification/memModel.sv
verification/icacheTb.sv

/* rtl/icacheCtrl.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icacheCtrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reqValid_i,
  input  icachePkg::addr_t      reqAddr_i,
  output logic                  reqReady_o,
  output logic                  respValid_o,
  input  logic                  respReady_i,
  output icachePkg::word_t      respData_o,
  input  icachePkg::line_t      way1Data_i,
  input  icachePkg::line_t      way2Data_i,
  input  logic                  way1Hit_i,
  input  logic                  way2Hit_i,
  input  icachePkg::line_t      refillLine_i,
  input  logic                  lineDone_i,
  output icachePkg::index_t     lookupIndex_o,
  output icachePkg::tag_t       lookupTag_o,
  output logic                  fillEn_o,
  input  logic                  fillWay_i,
  output logic                  refillActive_o,
  output logic                  sramEn_o,
  output logic                  way1Wen_o,
  output logic                  way2Wen_o,
  output icachePkg::index_t      sramIndex_o,
  output logic                  memReqValid_o,
  input  logic                  memReqReady_i,
  output icachePkg::addr_t      memAddr_o,
  output icachePkg::memLen_t    memLen_o
);

  localparam int RegionW = 4;

  icachePkg::ctrlState_e state, nextState;
  icachePkg::addr_t reqLatch;
  icachePkg::line_t srcLine;
  icachePkg::beatCnt_t wordSel;
  logic cached;
  logic lookupHit;
  logic reqAccept;

  assign cached = reqLatch[`ICACHE_ADDR_W-1 -: RegionW] == RegionW'(`ICACHE_CACHED_REGION);
  assign lookupHit = cached && (way1Hit_i || way2Hit_i);

  // lookup always uses the latched request
  assign lookupIndex_o = reqLatch[icachePkg::OFFSET_W +: icachePkg::INDEX_W];
  assign lookupTag_o = reqLatch[`ICACHE_ADDR_W-1 -: icachePkg::TAG_W];

  // a hit may hand over its response and take the next request together
  assign reqReady_o = (state == icachePkg::stIdle) ||
                      (state == icachePkg::stCompare && lookupHit && respReady_i);
  assign reqAccept = reqValid_i && reqReady_o;

  assign respValid_o = (state == icachePkg::stCompare && lookupHit) ||
                       (state == icachePkg::stRespond);

  always_ff @(posedge clk) begin
    if (reqAccept) begin
      reqLatch <= reqAddr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= icachePkg::stIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      icachePkg::stIdle: begin
        if (reqValid_i) begin
          nextState = icachePkg::stCompare;
        end
      end
      icachePkg::stCompare: begin
        if (!lookupHit) begin
          // uncached reads also take the miss path
          nextState = icachePkg::stMiss;
        end else if (respReady_i && !reqValid_i) begin
          nextState = icachePkg::stIdle;
        end
      end
      icachePkg::stMiss: begin
        if (memReqReady_i) begin
          nextState = icachePkg::stGetData;
        end
      end
      icachePkg::stGetData: begin
        if (lineDone_i) begin
          nextState = cached ? icachePkg::stReplace : icachePkg::stRespond;
        end
      end
      icachePkg::stReplace: begin
        nextState = icachePkg::stRespond;
      end
      icachePkg::stRespond: begin
        if (respReady_i) begin
          nextState = icachePkg::stIdle;
        end
      end
      default: begin
        nextState = icachePkg::stIdle;
      end
    endcase
  end

  // memory side
  assign memReqValid_o = state == icachePkg::stMiss;
  assign memAddr_o = cached ?
      {reqLatch[`ICACHE_ADDR_W-1:icachePkg::OFFSET_W], {icachePkg::OFFSET_W{1'b0}}} :
      reqLatch;
  assign memLen_o = cached ? icachePkg::memLen_t'(`ICACHE_LINE_BEATS - 1) : '0;
  assign refillActive_o = state == icachePkg::stGetData;

  // tag and data written in the same cycle, same way
  assign fillEn_o = state == icachePkg::stReplace;
  assign way1Wen_o = fillEn_o && !fillWay_i;
  assign way2Wen_o = fillEn_o && fillWay_i;

  // stores frozen unless a new request is taken or a line is written
  assign sramEn_o = reqAccept || fillEn_o;
  assign sramIndex_o = fillEn_o ? lookupIndex_o :
                       reqAddr_i[icachePkg::OFFSET_W +: icachePkg::INDEX_W];

  always_comb begin
    if (state == icachePkg::stRespond) begin
      srcLine = refillLine_i;
    end else if (way2Hit_i) begin
      srcLine = way2Data_i;
    end else begin
      srcLine = way1Data_i;
    end
  end

  // uncached data always sits in slot 0
  assign wordSel = (state == icachePkg::stRespond && !cached) ? '0 :
                   reqLatch[icachePkg::OFFSET_W-1 -: icachePkg::BEAT_W];
  assign respData_o = srcLine[wordSel * `ICACHE_XLEN +: `ICACHE_XLEN];

endmodule

/* rtl/icacheDataSram.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icacheDataSram (
  input  logic               clk,
  input  logic               en_i,
  input  logic               wen_i,
  input  icachePkg::index_t  addr_i,
  input  icachePkg::line_t   wdata_i,
  output icachePkg::line_t   rdata_o
);

  // one full line per set
  icachePkg::line_t mem [`ICACHE_SETS];

  // single port, so a write cycle leaves the read output alone
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (wen_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* rtl/icachePkg.sv */
`include "icache_settings.svh"

package icachePkg;

  // address split derived from the geometry
  localparam int OFFSET_W = $clog2(`ICACHE_XLEN / 8 * `ICACHE_LINE_BEATS);
  localparam int INDEX_W = $clog2(`ICACHE_SETS);
  localparam int TAG_W = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;
  localparam int BEAT_W = $clog2(`ICACHE_LINE_BEATS);

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [`ICACHE_XLEN-1:0] word_t;
  typedef logic [`ICACHE_XLEN*`ICACHE_LINE_BEATS-1:0] line_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [BEAT_W-1:0] beatCnt_t;
  // burst length as beats minus one
  typedef logic [7:0] memLen_t;

  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stMiss,
    stGetData,
    stReplace,
    stRespond
  } ctrlState_e;

endpackage

/* rtl/icacheRefill.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icacheRefill (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              active_i,
  input  logic              memRdValid_i,
  input  logic              memRdLast_i,
  input  icachePkg::word_t  memRdData_i,
  output logic              lineDone_o,
  output icachePkg::line_t  line_o
);

  icachePkg::beatCnt_t beatCnt;
  icachePkg::line_t lineBuf;
  logic beatTake;

  assign beatTake = active_i && memRdValid_i;

  // slot pointer, back to zero after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      if (memRdLast_i) begin
        beatCnt <= '0;
      end else begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // beats land lowest first, an uncached read only fills slot 0
  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineBuf[beatCnt * `ICACHE_XLEN +: `ICACHE_XLEN] <= memRdData_i;
    end
  end

  assign lineDone_o = beatTake && memRdLast_i;
  assign line_o = lineBuf;

endmodule

/* rtl/icacheTagStore.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icacheTagStore (
  input  logic               clk,
  input  logic               rst_n,
  input  icachePkg::index_t  index_i,
  input  icachePkg::tag_t    tag_i,
  input  logic               fillEn_i,
  output logic               way1Hit_o,
  output logic               way2Hit_o,
  output logic               fillWay_o
);

  // index 0 is way 1, index 1 is way 2
  icachePkg::tag_t tagMem [2][`ICACHE_SETS];
  logic [1:0][`ICACHE_SETS-1:0] validBits;

  // low selects way 1 for the next fill
  logic replBit;

  logic [1:0] wayHit;

  // both ways compared in parallel
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validBits[w][index_i] && (tagMem[w][index_i] == tag_i);
    end
  end

  assign way1Hit_o = wayHit[0];
  assign way2Hit_o = wayHit[1];
  assign fillWay_o = replBit;

  // valid bits and the toggle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      replBit <= 1'b0;
    end else if (fillEn_i) begin
      validBits[replBit][index_i] <= 1'b1;
      // every fill moves the victim to the other way
      replBit <= ~replBit;
    end
  end

  // tag written into the same way as the valid bit
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagMem[replBit][index_i] <= tag_i;
    end
  end

endmodule

/* rtl/icacheTop.sv */
`timescale 1ns/1ps

module icacheTop (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reqValid_i,
  input  icachePkg::addr_t    reqAddr_i,
  output logic                reqReady_o,
  output logic                respValid_o,
  input  logic                respReady_i,
  output icachePkg::word_t    respData_o,
  output logic                memReqValid_o,
  input  logic                memReqReady_i,
  output icachePkg::addr_t    memAddr_o,
  output icachePkg::memLen_t  memLen_o,
  input  logic                memRdValid_i,
  input  logic                memRdLast_i,
  input  icachePkg::word_t    memRdData_i
);

  icachePkg::line_t way1Data;
  icachePkg::line_t way2Data;
  icachePkg::line_t refillLine;
  icachePkg::index_t lookupIndex;
  icachePkg::index_t sramIndex;
  icachePkg::tag_t lookupTag;
  logic way1Hit;
  logic way2Hit;
  logic lineDone;
  logic fillEn;
  logic fillWay;
  logic refillActive;
  logic sramEn;
  logic way1Wen;
  logic way2Wen;

  icacheCtrl ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid_i),
    .reqAddr_i      (reqAddr_i),
    .reqReady_o     (reqReady_o),
    .respValid_o    (respValid_o),
    .respReady_i    (respReady_i),
    .respData_o     (respData_o),
    .way1Data_i     (way1Data),
    .way2Data_i     (way2Data),
    .way1Hit_i      (way1Hit),
    .way2Hit_i      (way2Hit),
    .refillLine_i   (refillLine),
    .lineDone_i     (lineDone),
    .lookupIndex_o  (lookupIndex),
    .lookupTag_o    (lookupTag),
    .fillEn_o       (fillEn),
    .fillWay_i      (fillWay),
    .refillActive_o (refillActive),
    .sramEn_o       (sramEn),
    .way1Wen_o      (way1Wen),
    .way2Wen_o      (way2Wen),
    .sramIndex_o    (sramIndex),
    .memReqValid_o  (memReqValid_o),
    .memReqReady_i  (memReqReady_i),
    .memAddr_o      (memAddr_o),
    .memLen_o       (memLen_o)
  );

  icacheTagStore tagStore (
    .clk       (clk),
    .rst_n     (rst_n),
    .index_i   (lookupIndex),
    .tag_i     (lookupTag),
    .fillEn_i  (fillEn),
    .way1Hit_o (way1Hit),
    .way2Hit_o (way2Hit),
    .fillWay_o (fillWay)
  );

  icacheRefill refill (
    .clk          (clk),
    .rst_n        (rst_n),
    .active_i     (refillActive),
    .memRdValid_i (memRdValid_i),
    .memRdLast_i  (memRdLast_i),
    .memRdData_i  (memRdData_i),
    .lineDone_o   (lineDone),
    .line_o       (refillLine)
  );

  // both ways share enable and index, only the write strobe differs
  icacheDataSram way1Store (
    .clk     (clk),
    .en_i    (sramEn),
    .wen_i   (way1Wen),
    .addr_i  (sramIndex),
    .wdata_i (refillLine),
    .rdata_o (way1Data)
  );

  icacheDataSram way2Store (
    .clk     (clk),
    .en_i    (sramEn),
    .wen_i   (way2Wen),
    .addr_i  (sramIndex),
    .wdata_i (refillLine),
    .rdata_o (way2Data)
  );

endmodule

/* rtl/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address and data path widths
`define ICACHE_ADDR_W 32
`define ICACHE_XLEN 64

// geometry per way
`define ICACHE_SETS 64
`define ICACHE_LINE_BEATS 4

// top address nibble that goes through the cache
`define ICACHE_CACHED_REGION 3

`endif

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  // released just after the fourth rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #5 rst_n_o = 1'b1;
  end

endmodule

/* verification/icacheTb.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icacheTb;

  localparam int NumReq = 400;
  // generous bound per request, in 100 ns cycles
  localparam int LimitCycles = NumReq * 60 + 100;

  typedef enum logic [1:0] {reqHit, reqMiss, reqUncached} reqKind_e;

  typedef struct packed {
    icachePkg::addr_t addr;
    reqKind_e kind;
    int acceptCycle;
    int firstValid;
    int memReqs;
  } pending_t;

  logic clk;
  logic rst_n;
  logic reqValid;
  icachePkg::addr_t reqAddr;
  logic reqReady;
  logic respValid;
  logic respReady;
  icachePkg::word_t respData;
  logic memReqValid;
  logic memReqReady;
  icachePkg::addr_t memAddr;
  icachePkg::memLen_t memLen;
  logic memRdValid;
  logic memRdLast;
  icachePkg::word_t memRdData;
  int memReqCount;

  integer seed;
  int errors;
  int cycle;
  int reqIdx;
  int respCount;
  int hits;
  int misses;
  int uncachedReads;
  int expMemReqs;
  logic holdReq;
  logic heldResp;
  icachePkg::word_t heldData;
  icachePkg::addr_t reqList [NumReq];
  pending_t pend [$];

  // mirror of the tag store
  icachePkg::tag_t modelTag [2][`ICACHE_SETS];
  logic modelValid [2][`ICACHE_SETS];
  logic modelFillWay;

  clockGen clockGen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  memModel memModel (
    .clk           (clk),
    .rst_n         (rst_n),
    .memReqValid_i (memReqValid),
    .memReqReady_o (memReqReady),
    .memAddr_i     (memAddr),
    .memLen_i      (memLen),
    .memRdValid_o  (memRdValid),
    .memRdLast_o   (memRdLast),
    .memRdData_o   (memRdData),
    .reqCount_o    (memReqCount)
  );

  icacheTop dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid),
    .reqAddr_i     (reqAddr),
    .reqReady_o    (reqReady),
    .respValid_o   (respValid),
    .respReady_i   (respReady),
    .respData_o    (respData),
    .memReqValid_o (memReqValid),
    .memReqReady_i (memReqReady),
    .memAddr_o     (memAddr),
    .memLen_o      (memLen),
    .memRdValid_i  (memRdValid),
    .memRdLast_i   (memRdLast),
    .memRdData_i   (memRdData)
  );

  task automatic checkWord(input string name, input icachePkg::word_t expected,
                           input icachePkg::word_t actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkAddr(input string name, input icachePkg::addr_t expected,
                           input icachePkg::addr_t actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkLen(input string name, input icachePkg::memLen_t expected,
                          input icachePkg::memLen_t actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // memory word for the 8-byte aligned address
  function automatic icachePkg::word_t expectedWord(input icachePkg::addr_t addr);
    icachePkg::addr_t base;
    base = addr & ~32'h7;
    return {base, ~base};
  endfunction

  function automatic icachePkg::addr_t makeAddr(input logic [16:0] tagLow,
                                                input icachePkg::index_t idx,
                                                input logic [4:0] off);
    return {4'(`ICACHE_CACHED_REGION), tagLow, idx, off};
  endfunction

  task automatic buildRequests();
    logic [16:0] tagPool [3];
    icachePkg::index_t setPool [3];
    icachePkg::addr_t uncachedPool [4];
    tagPool = '{17'h00012, 17'h0abcd, 17'h1f00e};
    setPool = '{6'd5, 6'd6, 6'd41};
    uncachedPool = '{32'h1000_2468, 32'h8000_0103, 32'h7ff0_00bc,
                     {4'h2, 17'h00012, 6'd5, 5'd8}};
    // three tags in set 5 force evictions early on
    reqList[0] = makeAddr(tagPool[0], 6'd5, 5'd0);
    reqList[1] = makeAddr(tagPool[1], 6'd5, 5'd8);
    reqList[2] = makeAddr(tagPool[2], 6'd5, 5'd16);
    reqList[3] = makeAddr(tagPool[0], 6'd5, 5'd24);
    reqList[4] = makeAddr(tagPool[1], 6'd5, 5'd4);
    reqList[5] = uncachedPool[3];
    reqList[6] = uncachedPool[3];
    for (int i = 7; i < NumReq; i++) begin
      if (randBelow(8) == 0) begin
        reqList[i] = uncachedPool[randBelow(4)];
      end else begin
        reqList[i] = makeAddr(tagPool[randBelow(3)], setPool[randBelow(3)],
                              5'(randBelow(32)));
      end
    end
  endtask

  task automatic classify(input icachePkg::addr_t addr, output reqKind_e kind);
    icachePkg::tag_t tag;
    icachePkg::index_t idx;
    logic hit;
    tag = addr[31:11];
    idx = addr[10:5];
    hit = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (modelValid[w][idx] && modelTag[w][idx] == tag) begin
        hit = 1'b1;
      end
    end
    if (addr[31:28] != 4'(`ICACHE_CACHED_REGION)) begin
      kind = reqUncached;
      uncachedReads++;
    end else if (hit) begin
      kind = reqHit;
      hits++;
    end else begin
      // one toggle for the whole cache, flipped by every fill
      kind = reqMiss;
      misses++;
      modelTag[modelFillWay][idx] = tag;
      modelValid[modelFillWay][idx] = 1'b1;
      modelFillWay = ~modelFillWay;
    end
  endtask

  task automatic driveInputs();
    if (!holdReq) begin
      if (reqIdx < NumReq && randBelow(4) != 0) begin
        reqValid = 1'b1;
        reqAddr = reqList[reqIdx];
      end else begin
        reqValid = 1'b0;
      end
    end
    respReady = randBelow(4) != 0;
  endtask

  task automatic sampleCycle();
    logic reqXfer;
    logic respXfer;
    pending_t entry;
    reqKind_e kind;
    int wantMem;
    reqXfer = reqValid && reqReady;
    respXfer = respValid && respReady;

    // back-pressure from the last cycle
    if (heldResp) begin
      if (!respValid) begin
        errors++;
        $display("response withdrawn at cycle %0d while respReady_i was low", cycle);
      end else begin
        checkWord($sformatf("held response cycle %0d", cycle), heldData, respData);
      end
    end
    if (respValid && !respReady && reqReady) begin
      errors++;
      $display("reqReady_o high at cycle %0d while the response was stalled", cycle);
    end
    heldResp = respValid && !respReady;
    heldData = respData;

    if (memReqValid && memReqReady) begin
      if (pend.size() == 0) begin
        errors++;
        $display("memory request at cycle %0d with no request outstanding", cycle);
      end else begin
        if (pend[0].kind == reqUncached) begin
          checkAddr("uncached memAddr_o", pend[0].addr, memAddr);
          checkLen("uncached memLen_o", '0, memLen);
        end else begin
          checkAddr("line memAddr_o", pend[0].addr & ~32'h1f, memAddr);
          checkLen("line memLen_o", 8'd3, memLen);
        end
        pend[0].memReqs = pend[0].memReqs + 1;
      end
    end

    if (respValid && pend.size() == 0) begin
      errors++;
      $display("response valid at cycle %0d with no request outstanding", cycle);
    end else if (respValid && pend[0].firstValid < 0) begin
      pend[0].firstValid = cycle;
    end

    if (respXfer && pend.size() > 0) begin
      entry = pend.pop_front();
      respCount++;
      checkWord($sformatf("response %0d addr %h", respCount, entry.addr),
                expectedWord(entry.addr), respData);
      wantMem = (entry.kind == reqHit) ? 0 : 1;
      if (entry.memReqs != wantMem) begin
        errors++;
        $display("Fail memory requests for addr %h: expected %0d, actual %0d",
                 entry.addr, wantMem, entry.memReqs);
      end
      if (entry.kind == reqHit && entry.firstValid != entry.acceptCycle + 1) begin
        errors++;
        $display("Fail hit latency for addr %h: expected valid in cycle %0d, actual %0d",
                 entry.addr, entry.acceptCycle + 1, entry.firstValid);
      end
    end

    if (reqXfer) begin
      classify(reqAddr, kind);
      entry.addr = reqAddr;
      entry.kind = kind;
      entry.acceptCycle = cycle;
      entry.firstValid = -1;
      entry.memReqs = 0;
      pend.push_back(entry);
      reqIdx++;
      if (kind != reqHit) begin
        expMemReqs++;
      end
      if (pend.size() > 1) begin
        errors++;
        $display("request %h accepted at cycle %0d before the previous one answered",
                 reqAddr, cycle);
      end
    end
    holdReq = reqValid && !reqReady;
  endtask

  // watchdog
  initial begin
    #(LimitCycles * 100);
    $display("timeout: run not finished after %0d cycles, %0d responses, %0d errors",
             LimitCycles, respCount, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    seed = 39;
    errors = 0;
    cycle = 0;
    reqIdx = 0;
    respCount = 0;
    hits = 0;
    misses = 0;
    uncachedReads = 0;
    expMemReqs = 0;
    reqValid = 1'b0;
    reqAddr = '0;
    respReady = 1'b0;
    holdReq = 1'b0;
    heldResp = 1'b0;
    heldData = '0;
    modelFillWay = 1'b0;
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        modelValid[w][s] = 1'b0;
        modelTag[w][s] = '0;
      end
    end
    buildRequests();

    @(posedge rst_n);
    @(negedge clk);
    if (reqReady !== 1'b1 || respValid !== 1'b0 || memReqValid !== 1'b0) begin
      errors++;
      $display("Fail reset state: expected ready 1 valid 0 memValid 0, actual %b %b %b",
               reqReady, respValid, memReqValid);
    end

    while (respCount < NumReq) begin
      @(posedge clk);
      cycle++;
      #5;
      driveInputs();
      @(negedge clk);
      sampleCycle();
    end

    if (memReqCount != expMemReqs) begin
      errors++;
      $display("Fail memory request total: expected %0d, actual %0d",
               expMemReqs, memReqCount);
    end
    $display("icacheTb: %0d requests, %0d hits, %0d misses, %0d uncached, %0d errors",
             respCount, hits, misses, uncachedReads, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verification/memModel.sv */
`timescale 1ns/1ps

module memModel (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                memReqValid_i,
  output logic                memReqReady_o,
  input  icachePkg::addr_t    memAddr_i,
  input  icachePkg::memLen_t  memLen_i,
  output logic                memRdValid_o,
  output logic                memRdLast_o,
  output icachePkg::word_t    memRdData_o,
  output int                  reqCount_o
);

  integer seed = 39;

  // upper half the aligned address, lower half its inverse
  function automatic icachePkg::word_t beatData(input icachePkg::addr_t addr);
    icachePkg::addr_t base;
    base = addr & ~32'h7;
    return {base, ~base};
  endfunction

  initial begin
    icachePkg::addr_t base;
    icachePkg::memLen_t len;
    int gap;
    memReqReady_o = 1'b0;
    memRdValid_o = 1'b0;
    memRdLast_o = 1'b0;
    memRdData_o = '0;
    reqCount_o = 0;
    forever begin
      @(negedge clk);
      if (rst_n && memReqValid_i) begin
        base = memAddr_i;
        len = memLen_i;
        reqCount_o++;
        // random wait before ready
        gap = int'($unsigned($random(seed)) % 3);
        repeat (gap + 1) @(posedge clk);
        #5 memReqReady_o = 1'b1;
        @(posedge clk);
        #5 memReqReady_o = 1'b0;
        // beats lowest first, sometimes with an idle cycle between them
        for (int b = 0; b <= int'(len); b++) begin
          gap = int'($unsigned($random(seed)) % 2);
          repeat (gap) begin
            @(posedge clk);
            #5;
          end
          memRdValid_o = 1'b1;
          memRdLast_o = (b == int'(len));
          memRdData_o = beatData(base + 32'(b * 8));
          @(posedge clk);
          #5 memRdValid_o = 1'b0;
          memRdLast_o = 1'b0;
        end
      end
    end
  end

endmodule
